// ==== hdl/delqa_bus_pkg.sv ====
// delqa host bus package: data widths, window offsets, bus owners, csr bit map
package delqa_bus_pkg;

	// ************************************************************
	// bus geometry
	localparam int DATA_W   = 16;	// q-bus data word
	localparam int SEL_W    = 2;	// byte lanes
	localparam int BDL_HI_W = 6;	// upper part of 22-bit descriptor address

	// word offsets inside the host register window
	typedef enum logic [2:0] {
		OFS_BLK     = 3'd0,	// local only: block bit
		OFS_RBDL_LO = 3'd2,
		OFS_RBDL_HI = 3'd3,
		OFS_TBDL_LO = 3'd4,
		OFS_TBDL_HI = 3'd5,
		OFS_VAR     = 3'd6,	// vector address
		OFS_CSR     = 3'd7
	} reg_ofs_e;

	// who currently holds the host window
	typedef enum logic [1:0] {
		OWN_NONE = 2'd0,
		OWN_EXT  = 2'd1,
		OWN_LOC  = 2'd2
	} bus_owner_e;

	// ************************************************************
	// csr bit positions
	localparam int CSR_RI = 15;	// receive int request
	localparam int CSR_CA = 13;	// carrier, read only
	localparam int CSR_OK = 12;	// link ok from phy
	localparam int CSR_SE = 10;	// sanity timer enable, storage only
	localparam int CSR_EL = 9;	// external loopback
	localparam int CSR_IL = 8;	// internal loopback, active low
	localparam int CSR_XI = 7;	// transmit int request
	localparam int CSR_IE = 6;	// interrupt enable
	localparam int CSR_RL = 5;	// rx list invalid
	localparam int CSR_XL = 4;	// tx list invalid
	localparam int CSR_BD = 3;	// boot/diag
	localparam int CSR_NI = 2;	// nxm interrupt
	localparam int CSR_RE = 0;	// receiver enable

endpackage

// ==== hdl/delqa_eth_pkg.sv ====
// delqa ethernet side package: control register widths, offsets and status bits
package delqa_eth_pkg;

	// ************************************************************
	// ethernet window, local bus only
	typedef enum logic [3:0] {
		ETH_MODE   = 4'd0,	// mode flags + rx status
		ETH_CNT    = 4'd1,	// tx count write, rx count read
		ETH_MDVAL  = 4'd2,	// mdio data
		ETH_MDCTRL = 4'd3,	// mdio control, status in high byte
		ETH_GPR    = 4'd4	// promisc, mcast, leds
	} eth_ofs_e;

	localparam int CNT_W    = 11;	// byte count, up to 2047
	localparam int MDCTRL_W = 7;	// {wr, start, reg[4:0]}
	localparam int MDSTAT_W = 8;
	localparam int STSE_W   = 8;
	localparam int MODE_W   = 10;

	// mdio control / status bits
	localparam int MD_START = 5;	// self clearing once phy goes busy
	localparam int MD_READY = 7;	// 1 - idle, 0 - busy
	localparam int MD_LINK  = 0;	// link up

	// rx/tx status bits
	localparam int STSE_RXRDY   = 6;
	localparam int STSE_CARRIER = 7;

endpackage

// ==== hdl/qbus_arbiter.sv ====
// qbus_arbiter: grants the host window to one bus and times both acknowledges
module qbus_arbiter import delqa_bus_pkg::*; (
	input  logic lwb_clk_i,
	input  logic comb_res,
	// local side
	input  logic lwb_cyc_i,
	input  logic lrg_stb_i,
	input  logic lwb_we_i,
	output logic lwb_ack_o,
	output logic lrd_req_o,	// one clock read request
	output logic lwr_req_o,	// one clock write request
	// external side
	input  logic ewb_cyc_i,
	input  logic erg_stb_i,
	input  logic ewb_we_i,
	output logic ewb_ack_o,
	output logic erd_req_o,
	output logic ewr_req_o
);

	bus_owner_e owner;
	logic [1:0] lack, eack;	// ack delay lines
	logic       lcyc, ecyc;
	logic       lstb, estb;

	assign lcyc = lwb_cyc_i & lrg_stb_i;
	assign ecyc = ewb_cyc_i & erg_stb_i;

	// ************************************************************
	// ownership, external wins a tie
	always_ff @(posedge lwb_clk_i, posedge comb_res) begin
		if (comb_res) begin
			owner <= OWN_NONE;
		end else begin
			case (owner)
				OWN_EXT: if (!ecyc) owner <= OWN_NONE;
				OWN_LOC: if (!lcyc) owner <= OWN_NONE;
				default: begin
					if (ecyc)
						owner <= OWN_EXT;
					else if (lcyc)
						owner <= OWN_LOC;
				end
			endcase
		end
	end

	// two stage ack per bus, only runs while granted
	always_ff @(posedge lwb_clk_i, posedge comb_res) begin
		if (comb_res) begin
			lack <= '0;
			eack <= '0;
		end else begin
			lack <= (owner == OWN_LOC) ? {lwb_cyc_i & lack[0], lcyc} : 2'b00;
			eack <= (owner == OWN_EXT) ? {ewb_cyc_i & eack[0], ecyc} : 2'b00;
		end
	end

	assign lwb_ack_o = lcyc & lack[1];	// drops with cyc or stb
	assign ewb_ack_o = ecyc & eack[1];

	// requests only for the owner, only until ack
	assign lstb = lcyc & (owner == OWN_LOC) & ~lwb_ack_o;
	assign estb = ecyc & (owner == OWN_EXT) & ~ewb_ack_o;

	assign lrd_req_o = lstb & ~lwb_we_i;
	assign lwr_req_o = lstb & lwb_we_i;
	assign erd_req_o = estb & ~ewb_we_i;
	assign ewr_req_o = estb & ewb_we_i;

endmodule

// ==== hdl/host_regs.sv ====
// host_regs: csr, var and descriptor list address registers shared by both buses
module host_regs import delqa_bus_pkg::*, delqa_eth_pkg::*; (
	input  logic                lwb_clk_i,
	input  logic                comb_res,
	input  logic                lrd_req_i,
	input  logic                lwr_req_i,
	input  logic                erd_req_i,
	input  logic                ewr_req_i,
	input  logic [2:0]          lwb_adr_i,
	input  logic [DATA_W-1:0]   lwb_dat_i,
	input  logic [SEL_W-1:0]    lwb_sel_i,
	input  logic [2:0]          ewb_adr_i,
	input  logic [DATA_W-1:0]   ewb_dat_i,
	input  logic [SEL_W-1:0]    ewb_sel_i,
	input  logic [STSE_W-1:0]   e_stse_i,	// carrier for ca
	input  logic [MDSTAT_W-1:0] e_mdstat_i,	// link for ok
	output logic [DATA_W-1:0]   lrd_dat_o,
	output logic [DATA_W-1:0]   ewb_dat_o,
	output logic                csr_ri_o,
	output logic                csr_xi_o,
	output logic                csr_ie_o,
	output logic [3:0]          mode_bits_o	// {il, el, re, bd}
);

	logic csr_ri, csr_se, csr_el, csr_il, csr_xi, csr_ie;
	logic csr_rl, csr_xl, csr_bd, csr_ni, csr_re;
	logic blk;	// local lock on external writes

	logic [DATA_W-1:1]   rbdl_lo, tbdl_lo;	// word aligned
	logic [BDL_HI_W-1:0] rbdl_hi, tbdl_hi;
	logic                var_ms, var_id;
	logic [7:0]          var_iv;	// vector bits 9:2

	logic [DATA_W-1:0] csr;
	logic [DATA_W-1:0] win [8];	// read view of the window
	reg_ofs_e          e_ofs, l_ofs;
	logic              e_wr_lo, e_wr_hi, l_wr_lo, l_wr_hi;
	logic              allow;

	assign e_ofs   = reg_ofs_e'(ewb_adr_i);
	assign l_ofs   = reg_ofs_e'(lwb_adr_i);
	assign e_wr_lo = ewr_req_i & ewb_sel_i[0];
	assign e_wr_hi = ewr_req_i & ewb_sel_i[1];
	assign l_wr_lo = lwr_req_i & lwb_sel_i[0];
	assign l_wr_hi = lwr_req_i & lwb_sel_i[1];
	assign allow   = ~blk;

	// ************************************************************
	// read side
	always_comb begin
		csr         = '0;	// sr, pe and spare bits read 0
		csr[CSR_RI] = csr_ri;
		csr[CSR_CA] = csr_il & e_stse_i[STSE_CARRIER];
		csr[CSR_OK] = e_mdstat_i[MD_LINK];
		csr[CSR_SE] = csr_se;
		csr[CSR_EL] = csr_el;
		csr[CSR_IL] = csr_il;
		csr[CSR_XI] = csr_xi;
		csr[CSR_IE] = csr_ie;
		csr[CSR_RL] = csr_rl;
		csr[CSR_XL] = csr_xl;
		csr[CSR_BD] = csr_bd;
		csr[CSR_NI] = csr_ni;
		csr[CSR_RE] = csr_re;

		win[OFS_BLK]     = {{(DATA_W-1){1'b0}}, blk};
		win[1]           = '0;	// hole
		win[OFS_RBDL_LO] = {rbdl_lo, 1'b0};
		win[OFS_RBDL_HI] = {{(DATA_W-BDL_HI_W){1'b0}}, rbdl_hi};
		win[OFS_TBDL_LO] = {tbdl_lo, 1'b0};
		win[OFS_TBDL_HI] = {{(DATA_W-BDL_HI_W){1'b0}}, tbdl_hi};
		win[OFS_VAR]     = {var_ms, 5'b0, var_iv, 1'b0, var_id};
		win[OFS_CSR]     = csr;
	end

	// data held through ack
	always_ff @(posedge lwb_clk_i) begin
		if (erd_req_i)
			ewb_dat_o <= win[ewb_adr_i];
		if (lrd_req_i)
			lrd_dat_o <= win[lwb_adr_i];
	end

	// ************************************************************
	// address and vector storage
	always_ff @(posedge lwb_clk_i) begin
		if (e_wr_lo && allow) begin
			case (e_ofs)
				OFS_RBDL_LO: rbdl_lo[7:1] <= ewb_dat_i[7:1];
				OFS_RBDL_HI: rbdl_hi      <= ewb_dat_i[BDL_HI_W-1:0];
				OFS_TBDL_LO: tbdl_lo[7:1] <= ewb_dat_i[7:1];
				OFS_TBDL_HI: tbdl_hi      <= ewb_dat_i[BDL_HI_W-1:0];
				default: ;
			endcase
		end
		if (e_wr_hi && allow) begin
			case (e_ofs)
				OFS_RBDL_LO: rbdl_lo[DATA_W-1:8] <= ewb_dat_i[DATA_W-1:8];
				OFS_TBDL_LO: tbdl_lo[DATA_W-1:8] <= ewb_dat_i[DATA_W-1:8];
				default: ;
			endcase
		end
		// var ignores the block bit
		if (e_wr_lo && e_ofs == OFS_VAR) begin
			var_iv[5:0] <= ewb_dat_i[7:2];
			var_id      <= ewb_dat_i[0];	// identity test
		end
		if (e_wr_hi && e_ofs == OFS_VAR) begin
			var_iv[7:6] <= ewb_dat_i[9:8];
			var_ms      <= ewb_dat_i[15];
		end
	end

	// ************************************************************
	// csr and block bit
	always_ff @(posedge lwb_clk_i, posedge comb_res) begin
		if (comb_res) begin
			{csr_ri, csr_se, csr_el, csr_il, csr_xi, csr_ie} <= '0;
			{csr_bd, csr_ni, csr_re, blk} <= '0;
			csr_rl <= 1'b1;	// lists start invalid
			csr_xl <= 1'b1;
		end else begin
			// external bus, guarded by blk
			if (e_wr_lo && allow && e_ofs == OFS_CSR) begin
				csr_ie <= ewb_dat_i[CSR_IE];
				csr_re <= ewb_dat_i[CSR_RE];
				csr_bd <= ewb_dat_i[CSR_BD];
				if (ewb_dat_i[CSR_XI]) begin	// write 1 to clear
					csr_xi <= 1'b0;
					csr_ni <= 1'b0;
				end
			end
			if (e_wr_hi && allow) begin
				case (e_ofs)
					OFS_RBDL_HI: csr_rl <= 1'b0;	// list now valid
					OFS_TBDL_HI: csr_xl <= 1'b0;
					OFS_CSR: begin
						csr_il <= ewb_dat_i[CSR_IL];
						csr_el <= ewb_dat_i[CSR_EL];
						csr_se <= ewb_dat_i[CSR_SE];
						if (ewb_dat_i[CSR_RI])
							csr_ri <= 1'b0;
					end
					default: ;
				endcase
			end
			// local bus sets status directly
			if (l_wr_lo) begin
				case (l_ofs)
					OFS_BLK: blk <= lwb_dat_i[0];
					OFS_CSR: begin
						csr_ni <= lwb_dat_i[CSR_NI];
						csr_xl <= lwb_dat_i[CSR_XL];
						csr_rl <= lwb_dat_i[CSR_RL];
						csr_xi <= lwb_dat_i[CSR_XI];
					end
					default: ;
				endcase
			end
			if (l_wr_hi && l_ofs == OFS_CSR)
				csr_ri <= lwb_dat_i[CSR_RI];
		end
	end

	assign csr_ri_o    = csr_ri;
	assign csr_xi_o    = csr_xi;
	assign csr_ie_o    = csr_ie;
	assign mode_bits_o = {csr_il, csr_el, csr_re, csr_bd};

endmodule

// ==== hdl/eth_regs.sv ====
// eth_regs: local-only ethernet control bank with mode decode, mdio and leds
module eth_regs import delqa_bus_pkg::*, delqa_eth_pkg::*; (
	input  logic                lwb_clk_i,
	input  logic                comb_res,
	input  logic                lwb_cyc_i,
	input  logic                let_stb_i,
	input  logic                lwb_we_i,
	input  logic [3:0]          lwb_adr_i,
	input  logic [DATA_W-1:0]   lwb_dat_i,
	input  logic [SEL_W-1:0]    lwb_sel_i,
	input  logic [3:0]          mode_bits_i,	// {il, el, re, bd} from csr
	input  logic [STSE_W-1:0]   e_stse_i,
	input  logic [CNT_W-1:0]    e_rxcntb_i,
	input  logic [DATA_W-1:0]   e_mdval_i,
	input  logic [MDSTAT_W-1:0] e_mdstat_i,
	output logic                let_ack_o,
	output logic [DATA_W-1:0]   etdat_o,
	output logic [MODE_W-1:0]   e_mode_o,
	output logic [CNT_W-1:0]    e_txcntb_o,
	output logic [DATA_W-1:0]   e_mdval_o,
	output logic [MDCTRL_W-1:0] e_mdctrl_o,
	output logic [2:0]          dev_ind_o
);

	logic       rxdon, txrdy, skipb, stpac;	// mode flags
	logic       promis, mcast;
	logic [1:0] etack;
	logic       il, el, re, bd;
	logic       intmode, intextmode, extmode, rxmode;
	logic       estb, erd, ewr;
	eth_ofs_e   ofs;

	assign {il, el, re, bd} = mode_bits_i;
	assign ofs = eth_ofs_e'(lwb_adr_i);

	// ************************************************************
	// own ack, two edges, no arbitration
	always_ff @(posedge lwb_clk_i, posedge comb_res) begin
		if (comb_res)
			etack <= '0;
		else
			etack <= {lwb_cyc_i & etack[0], lwb_cyc_i & let_stb_i};
	end

	assign let_ack_o = lwb_cyc_i & let_stb_i & etack[1];
	assign estb = lwb_cyc_i & let_stb_i & ~let_ack_o;
	assign erd  = estb & ~lwb_we_i;
	assign ewr  = estb & lwb_we_i;

	// loopback / rx mode decode
	assign intmode    = ~il & ~el & ~re;
	assign intextmode = ~il & el & ~re & ~bd;
	assign extmode    = il & el & ~re;
	assign rxmode     = re;

	assign e_mode_o = {promis, mcast, rxdon, txrdy, skipb, stpac,
		extmode, intextmode, intmode, rxmode};

	// ************************************************************
	// reads
	always_ff @(posedge lwb_clk_i) begin
		if (erd) begin
			case (ofs)
				ETH_MODE:   etdat_o <= {1'b0, e_stse_i[6:0], e_mode_o[7:0]};
				ETH_CNT:    etdat_o <= {{(DATA_W-CNT_W){1'b0}}, e_rxcntb_i};
				ETH_MDVAL:  etdat_o <= e_mdval_i;
				ETH_MDCTRL: etdat_o <= {e_mdstat_i, 1'b0, e_mdctrl_o};
				ETH_GPR:    etdat_o <= {9'b0, promis, mcast, 2'b0, dev_ind_o};
				default:    etdat_o <= '0;
			endcase
		end
	end

	// writes and self clearing bits
	always_ff @(posedge lwb_clk_i, posedge comb_res) begin
		if (comb_res) begin
			{rxdon, txrdy, skipb, stpac, promis, mcast} <= '0;
			e_txcntb_o <= '0;
			e_mdval_o  <= '0;
			e_mdctrl_o <= '0;
			dev_ind_o  <= '0;
		end else if (ewr) begin
			if (lwb_sel_i[0]) begin
				case (ofs)
					ETH_MODE:   {rxdon, txrdy, skipb, stpac} <= lwb_dat_i[7:4];
					ETH_CNT:    e_txcntb_o[7:0] <= lwb_dat_i[7:0];
					ETH_MDVAL:  e_mdval_o[7:0]  <= lwb_dat_i[7:0];
					ETH_MDCTRL: e_mdctrl_o      <= lwb_dat_i[MDCTRL_W-1:0];
					ETH_GPR: begin
						promis    <= lwb_dat_i[6];
						mcast     <= lwb_dat_i[5];
						dev_ind_o <= lwb_dat_i[2:0];	// leds
					end
					default: ;
				endcase
			end
			if (lwb_sel_i[1]) begin
				case (ofs)
					ETH_CNT:   e_txcntb_o[CNT_W-1:8] <= lwb_dat_i[CNT_W-1:8];
					ETH_MDVAL: e_mdval_o[DATA_W-1:8] <= lwb_dat_i[DATA_W-1:8];
					default: ;
				endcase
			end
		end else begin
			if (!e_stse_i[STSE_RXRDY])	// rx buffer released
				rxdon <= 1'b0;
			if (!e_mdstat_i[MD_READY])	// mdio picked up the start
				e_mdctrl_o[MD_START] <= 1'b0;
		end
	end

endmodule

// ==== hdl/int_ctrl.sv ====
// int_ctrl: edge detect on rx/tx requests and the q-bus irq latch
module int_ctrl (
	input  logic lwb_clk_i,
	input  logic comb_res,
	input  logic ri_i,
	input  logic xi_i,
	input  logic ie_i,
	input  logic iack_i,	// vector taken
	output logic irq_o
);

	logic req, req_d;

	assign req = ri_i | xi_i;

	always_ff @(posedge lwb_clk_i, posedge comb_res) begin
		if (comb_res) begin
			req_d <= 1'b0;
			irq_o <= 1'b0;
		end else begin
			req_d <= req;
			if (iack_i || !ie_i)	// served or masked
				irq_o <= 1'b0;
			else if (req && !req_d)	// new request only
				irq_o <= 1'b1;
		end
	end

endmodule

// ==== hdl/delqa_regs.sv ====
// delqa_regs: delqa register file top, arbiter, host and ethernet banks, interrupt
module delqa_regs import delqa_bus_pkg::*, delqa_eth_pkg::*; (
	input  logic                lwb_clk_i,
	input  logic                comb_res,
	// local processor bus
	input  logic [3:0]          lwb_adr_i,
	input  logic [DATA_W-1:0]   lwb_dat_i,
	output logic [DATA_W-1:0]   lwb_dat_o,
	input  logic                lwb_cyc_i,
	input  logic                lwb_we_i,
	input  logic [SEL_W-1:0]    lwb_sel_i,
	input  logic                lrg_stb_i,	// host window
	input  logic                let_stb_i,	// ethernet window
	output logic                lwb_ack_o,
	// external host bus
	input  logic [2:0]          ewb_adr_i,
	input  logic [DATA_W-1:0]   ewb_dat_i,
	output logic [DATA_W-1:0]   ewb_dat_o,
	input  logic                ewb_cyc_i,
	input  logic                ewb_we_i,
	input  logic [SEL_W-1:0]    ewb_sel_i,
	input  logic                erg_stb_i,
	output logic                ewb_ack_o,
	input  logic                iack_i,
	output logic                irq_o,
	// ethernet core
	output logic [MODE_W-1:0]   e_mode_o,
	input  logic [STSE_W-1:0]   e_stse_i,
	output logic [CNT_W-1:0]    e_txcntb_o,
	input  logic [CNT_W-1:0]    e_rxcntb_i,
	output logic [DATA_W-1:0]   e_mdval_o,
	input  logic [DATA_W-1:0]   e_mdval_i,
	output logic [MDCTRL_W-1:0] e_mdctrl_o,
	input  logic [MDSTAT_W-1:0] e_mdstat_i,
	output logic [2:0]          dev_ind_o
);

	logic              lrg_ack, let_ack;
	logic              lrd_req, lwr_req, erd_req, ewr_req;
	logic [DATA_W-1:0] lrd_dat, etdat;
	logic              csr_ri, csr_xi, csr_ie;
	logic [3:0]        mode_bits;

	// ************************************************************
	// front end
	qbus_arbiter u_arb (
		.lwb_clk_i (lwb_clk_i),
		.comb_res  (comb_res),
		.lwb_cyc_i (lwb_cyc_i),
		.lrg_stb_i (lrg_stb_i),
		.lwb_we_i  (lwb_we_i),
		.lwb_ack_o (lrg_ack),
		.lrd_req_o (lrd_req),
		.lwr_req_o (lwr_req),
		.ewb_cyc_i (ewb_cyc_i),
		.erg_stb_i (erg_stb_i),
		.ewb_we_i  (ewb_we_i),
		.ewb_ack_o (ewb_ack_o),
		.erd_req_o (erd_req),
		.ewr_req_o (ewr_req)
	);

	// register stage
	host_regs u_host (
		.lwb_clk_i   (lwb_clk_i),
		.comb_res    (comb_res),
		.lrd_req_i   (lrd_req),
		.lwr_req_i   (lwr_req),
		.erd_req_i   (erd_req),
		.ewr_req_i   (ewr_req),
		.lwb_adr_i   (lwb_adr_i[2:0]),
		.lwb_dat_i   (lwb_dat_i),
		.lwb_sel_i   (lwb_sel_i),
		.ewb_adr_i   (ewb_adr_i),
		.ewb_dat_i   (ewb_dat_i),
		.ewb_sel_i   (ewb_sel_i),
		.e_stse_i    (e_stse_i),
		.e_mdstat_i  (e_mdstat_i),
		.lrd_dat_o   (lrd_dat),
		.ewb_dat_o   (ewb_dat_o),
		.csr_ri_o    (csr_ri),
		.csr_xi_o    (csr_xi),
		.csr_ie_o    (csr_ie),
		.mode_bits_o (mode_bits)
	);

	// ethernet bank beside the register stage
	eth_regs u_eth (
		.lwb_clk_i   (lwb_clk_i),
		.comb_res    (comb_res),
		.lwb_cyc_i   (lwb_cyc_i),
		.let_stb_i   (let_stb_i),
		.lwb_we_i    (lwb_we_i),
		.lwb_adr_i   (lwb_adr_i),
		.lwb_dat_i   (lwb_dat_i),
		.lwb_sel_i   (lwb_sel_i),
		.mode_bits_i (mode_bits),
		.e_stse_i    (e_stse_i),
		.e_rxcntb_i  (e_rxcntb_i),
		.e_mdval_i   (e_mdval_i),
		.e_mdstat_i  (e_mdstat_i),
		.let_ack_o   (let_ack),
		.etdat_o     (etdat),
		.e_mode_o    (e_mode_o),
		.e_txcntb_o  (e_txcntb_o),
		.e_mdval_o   (e_mdval_o),
		.e_mdctrl_o  (e_mdctrl_o),
		.dev_ind_o   (dev_ind_o)
	);

	// interrupt stage
	int_ctrl u_int (
		.lwb_clk_i (lwb_clk_i),
		.comb_res  (comb_res),
		.ri_i      (csr_ri),
		.xi_i      (csr_xi),
		.ie_i      (csr_ie),
		.iack_i    (iack_i),
		.irq_o     (irq_o)
	);

	// local read mux, host window has priority
	assign lwb_dat_o = lrg_stb_i ? lrd_dat : etdat;
	assign lwb_ack_o = lrg_ack | let_ack;

endmodule

// ==== testbench/tb_delqa_regs.sv ====
// tb_delqa_regs: testbench for the delqa register file, both buses, irq and ethernet bank
module tb_delqa_regs import delqa_bus_pkg::*, delqa_eth_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 6;
	localparam int ACK_LIMIT = 50;	// cycles a bus task waits for ack

	logic                lwb_clk_i, comb_res;
	logic [3:0]          lwb_adr_i;
	logic [DATA_W-1:0]   lwb_dat_i, lwb_dat_o;
	logic                lwb_cyc_i, lwb_we_i, lrg_stb_i, let_stb_i, lwb_ack_o;
	logic [SEL_W-1:0]    lwb_sel_i;
	logic [2:0]          ewb_adr_i;
	logic [DATA_W-1:0]   ewb_dat_i, ewb_dat_o;
	logic                ewb_cyc_i, ewb_we_i, erg_stb_i, ewb_ack_o;
	logic [SEL_W-1:0]    ewb_sel_i;
	logic                iack_i, irq_o;
	logic [MODE_W-1:0]   e_mode_o;
	logic [STSE_W-1:0]   e_stse_i;
	logic [CNT_W-1:0]    e_txcntb_o, e_rxcntb_i;
	logic [DATA_W-1:0]   e_mdval_o, e_mdval_i;
	logic [MDCTRL_W-1:0] e_mdctrl_o;
	logic [MDSTAT_W-1:0] e_mdstat_i;
	logic [2:0]          dev_ind_o;

	int          errors, tests, test_err0;
	logic [31:0] lcg_state;
	time         ext_end_t, loc_ack_t;	// ordering of the contested cycles
	logic        e_act, l_act, t_act;	// cycle active per window
	logic        irq_req, irq_en;

	delqa_regs u_delqa_regs (.*);

	initial lwb_clk_i = 1'b0;
	always #4 lwb_clk_i = ~lwb_clk_i;	// 8 ns period

	assign e_act   = ewb_cyc_i & erg_stb_i;
	assign l_act   = lwb_cyc_i & lrg_stb_i;
	assign t_act   = lwb_cyc_i & let_stb_i;
	assign irq_req = u_delqa_regs.csr_ri | u_delqa_regs.csr_xi;
	assign irq_en  = u_delqa_regs.csr_ie;

	// ************************************************************
	// ack latency, host window 3 edges, ethernet window 2 edges
	ext_early: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		ewb_ack_o |-> $past(e_act) && $past(e_act, 2) && $past(e_act, 3))
		else count_failure("external ack came less than 3 edges into its cycle");
	ext_ontime: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		(e_act && $past(e_act) && $past(e_act, 2) && $past(e_act, 3) && !$past(e_act, 4)
		&& !$past(l_act, 4)) |-> ewb_ack_o)
		else count_failure("external ack missing 3 edges into a free cycle");
	loc_early: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		(lwb_ack_o && lrg_stb_i) |-> $past(l_act) && $past(l_act, 2) && $past(l_act, 3))
		else count_failure("local host ack came less than 3 edges into its cycle");
	loc_ontime: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		(l_act && $past(l_act) && $past(l_act, 2) && $past(l_act, 3) && !$past(l_act, 4)
		&& !$past(e_act, 3) && !$past(e_act, 4)) |-> lwb_ack_o)
		else count_failure("local host ack missing 3 edges into a free cycle");
	eth_early: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		(lwb_ack_o && let_stb_i) |-> $past(t_act) && $past(t_act, 2))
		else count_failure("ethernet ack came less than 2 edges into its cycle");
	eth_ontime: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		(t_act && $past(t_act) && $past(t_act, 2) && !$past(t_act, 3)) |-> lwb_ack_o)
		else count_failure("ethernet ack missing 2 edges into its cycle");

	// irq one edge after a new ri/xi request with ie set
	irq_rise: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		$rose(irq_o) |-> $past(irq_req) && !$past(irq_req, 2) && $past(irq_en))
		else count_failure("irq_o rose without a new request under ie");
	irq_set: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		($past(irq_req) && !$past(irq_req, 2) && $past(irq_en) && !$past(iack_i))
		|-> irq_o)
		else count_failure("irq_o did not follow a new request under ie");
	irq_clear: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		($past(iack_i) || !$past(irq_en)) |-> !irq_o)
		else count_failure("irq_o stayed high after iack or with ie low");

	// ************************************************************
	task automatic count_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic check_val(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] want);
		chk: assert (got === want)
			else count_failure($sformatf("error %s: got 0x%04h, expected 0x%04h",
				name, got, want));
	endtask

	function automatic logic [DATA_W-1:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];	// upper half, better spread
	endfunction

	// {ext, int-ext, int, rx} from il, el, re, bd
	function automatic logic [3:0] mode_decode(input logic il, el, re, bd);
		return {il & el & ~re, ~il & el & ~re & ~bd, ~il & ~el & ~re, re};
	endfunction

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %0d failed checks", tests, name, errors - test_err0);
		test_err0 = errors;
	endtask

	// external host window cycle, data taken while ack is high
	task automatic ext_cycle(input logic we, input logic [2:0] adr,
		input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
		output logic [DATA_W-1:0] rdat);
		int n;
		n = 0;
		@(posedge lwb_clk_i);
		#1;
		ewb_adr_i = adr;
		ewb_dat_i = dat;
		ewb_sel_i = sel;
		ewb_we_i  = we;
		ewb_cyc_i = 1'b1;
		erg_stb_i = 1'b1;
		@(negedge lwb_clk_i);
		while (!ewb_ack_o && n < ACK_LIMIT) begin
			@(negedge lwb_clk_i);
			n++;
		end
		if (!ewb_ack_o)
			count_failure("external bus cycle got no ack");
		rdat = ewb_dat_o;
		@(posedge lwb_clk_i);
		#1;
		ewb_cyc_i = 1'b0;
		erg_stb_i = 1'b0;
		ewb_we_i  = 1'b0;
		ext_end_t = $time;
	endtask

	// local cycle, eth picks the ethernet window over the host window
	task automatic loc_cycle(input logic eth, input logic we, input logic [3:0] adr,
		input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
		output logic [DATA_W-1:0] rdat);
		int n;
		n = 0;
		@(posedge lwb_clk_i);
		#1;
		lwb_adr_i = adr;
		lwb_dat_i = dat;
		lwb_sel_i = sel;
		lwb_we_i  = we;
		lwb_cyc_i = 1'b1;
		lrg_stb_i = ~eth;
		let_stb_i = eth;
		@(negedge lwb_clk_i);
		while (!lwb_ack_o && n < ACK_LIMIT) begin
			@(negedge lwb_clk_i);
			n++;
		end
		if (!lwb_ack_o)
			count_failure("local bus cycle got no ack");
		loc_ack_t = $time;
		rdat = lwb_dat_o;	// mux still on the right window
		@(posedge lwb_clk_i);
		#1;
		lwb_cyc_i = 1'b0;
		lrg_stb_i = 1'b0;
		let_stb_i = 1'b0;
		lwb_we_i  = 1'b0;
	endtask

	task automatic ext_write(input logic [2:0] adr, input logic [DATA_W-1:0] dat,
		input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] unused;
		ext_cycle(1'b1, adr, dat, sel, unused);
	endtask

	task automatic ext_expect(input logic [2:0] adr, input logic [DATA_W-1:0] want,
		input string name);
		logic [DATA_W-1:0] got;
		ext_cycle(1'b0, adr, '0, 2'b11, got);
		check_val(name, got, want);
	endtask

	task automatic loc_write(input logic eth, input logic [3:0] adr,
		input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] unused;
		loc_cycle(eth, 1'b1, adr, dat, sel, unused);
	endtask

	task automatic loc_expect(input logic eth, input logic [3:0] adr,
		input logic [DATA_W-1:0] want, input string name);
		logic [DATA_W-1:0] got;
		loc_cycle(eth, 1'b0, adr, '0, 2'b11, got);
		check_val(name, got, want);
	endtask

	// ************************************************************
	// watchdog, 200 cycles per test
	initial begin
		repeat (NUM_TESTS * 200) @(posedge lwb_clk_i);
		$display("watchdog: run did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [DATA_W-1:0] rb, tb, val, wdat, want;
		logic              il, el, re;
		int                n;
		lcg_state = 32'd83;
		errors    = 0;
		tests     = 0;
		test_err0 = 0;
		ext_end_t = 0;
		loc_ack_t = 0;
		comb_res  = 1'b1;
		lwb_adr_i = '0;
		lwb_dat_i = '0;
		lwb_cyc_i = 1'b0;
		lwb_we_i  = 1'b0;
		lwb_sel_i = '0;
		lrg_stb_i = 1'b0;
		let_stb_i = 1'b0;
		ewb_adr_i = '0;
		ewb_dat_i = '0;
		ewb_cyc_i = 1'b0;
		ewb_we_i  = 1'b0;
		ewb_sel_i = '0;
		erg_stb_i = 1'b0;
		iack_i    = 1'b0;
		e_stse_i  = '0;
		e_rxcntb_i = '0;
		e_mdval_i  = '0;
		e_mdstat_i = '0;
		repeat (8) @(posedge lwb_clk_i);
		#1;
		comb_res = 1'b0;

		// 1: reset values, only rl and xl set
		ext_expect(OFS_CSR, 16'h0030, "ewb_dat_o csr");
		loc_expect(1'b0, {1'b0, OFS_CSR}, 16'h0030, "lwb_dat_o csr");
		check_val("irq_o", 16'(irq_o), 16'h0000);
		check_val("e_mode_o", 16'(e_mode_o), 16'(mode_decode(1'b0, 1'b0, 1'b0, 1'b0)));
		finish_test("reset values");

		// 2: loopback and receive mode bits, every il/el/re combination
		e_stse_i = 8'h80;	// carrier present
		for (int m = 0; m < 8; m++) begin
			il   = m[2];
			el   = m[1];
			re   = m[0];
			wdat = '0;
			wdat[CSR_IL] = il;
			wdat[CSR_EL] = el;
			wdat[CSR_RE] = re;
			want = wdat | 16'h0030;	// rl, xl untouched
			want[CSR_CA] = il;	// ca = il and carrier
			ext_write(OFS_CSR, wdat, 2'b11);
			ext_expect(OFS_CSR, want, "ewb_dat_o csr");
			check_val("e_mode_o[3:0]", 16'(e_mode_o[3:0]), 16'(mode_decode(il, el, re, 1'b0)));
		end
		ext_write(OFS_CSR, 16'h0000, 2'b11);
		e_stse_i = '0;
		finish_test("csr mode bits");

		// 3: descriptor list addresses, list valid bits, block bit
		rb  = rand16();
		val = rand16();
		ext_write(OFS_RBDL_LO, rb, 2'b11);
		ext_write(OFS_RBDL_HI, val, 2'b01);	// low byte keeps rl
		ext_expect(OFS_RBDL_LO, rb & 16'hfffe, "ewb_dat_o rbdl_lo");
		loc_expect(1'b0, {1'b0, OFS_RBDL_LO}, rb & 16'hfffe, "lwb_dat_o rbdl_lo");
		ext_expect(OFS_RBDL_HI, val & 16'h003f, "ewb_dat_o rbdl_hi");
		ext_write(OFS_RBDL_HI, 16'hff00, 2'b10);
		ext_expect(OFS_CSR, 16'h0010, "ewb_dat_o csr");	// rl cleared
		tb  = rand16();
		val = rand16();
		ext_write(OFS_TBDL_LO, tb, 2'b11);
		ext_write(OFS_TBDL_HI, val, 2'b01);
		ext_expect(OFS_TBDL_LO, tb & 16'hfffe, "ewb_dat_o tbdl_lo");
		loc_expect(1'b0, {1'b0, OFS_TBDL_HI}, val & 16'h003f, "lwb_dat_o tbdl_hi");
		ext_write(OFS_TBDL_HI, 16'hff00, 2'b10);
		ext_expect(OFS_CSR, 16'h0000, "ewb_dat_o csr");	// xl cleared
		loc_write(1'b0, {1'b0, OFS_BLK}, 16'h0001, 2'b01);
		ext_write(OFS_RBDL_LO, ~rb, 2'b11);	// both ignored under block
		ext_write(OFS_TBDL_LO, ~tb, 2'b11);
		ext_expect(OFS_RBDL_LO, rb & 16'hfffe, "ewb_dat_o rbdl_lo");
		ext_expect(OFS_TBDL_LO, tb & 16'hfffe, "ewb_dat_o tbdl_lo");
		val = rand16();
		ext_write(OFS_VAR, val, 2'b11);	// var still writable
		ext_expect(OFS_VAR, val & 16'h83fd, "ewb_dat_o var");
		loc_write(1'b0, {1'b0, OFS_BLK}, 16'h0000, 2'b01);
		finish_test("descriptor lists and block");

		// 4: xi from the local side raises irq, iack clears it
		ext_write(OFS_CSR, 16'h0040, 2'b01);	// ie
		loc_write(1'b0, {1'b0, OFS_CSR}, 16'h0080, 2'b01);	// xi
		n = 0;
		while (!irq_o && n < 10) begin
			@(negedge lwb_clk_i);
			n++;
		end
		check_val("irq_o", 16'(irq_o), 16'h0001);
		@(posedge lwb_clk_i);
		#1;
		iack_i = 1'b1;
		@(posedge lwb_clk_i);
		#1;
		iack_i = 1'b0;
		@(negedge lwb_clk_i);
		check_val("irq_o", 16'(irq_o), 16'h0000);
		ext_write(OFS_CSR, 16'h00c0, 2'b01);	// write 1 clears xi, ie kept
		ext_expect(OFS_CSR, 16'h0040, "ewb_dat_o csr");
		repeat (4) @(negedge lwb_clk_i);
		check_val("irq_o", 16'(irq_o), 16'h0000);
		ext_write(OFS_CSR, 16'h0000, 2'b01);
		finish_test("interrupt");

		// 5: ethernet bank outputs and mdio start
		val = rand16();
		loc_write(1'b1, ETH_CNT, val, 2'b11);
		check_val("e_txcntb_o", 16'(e_txcntb_o), val & 16'h07ff);
		val = rand16();
		loc_write(1'b1, ETH_MDVAL, val, 2'b11);
		check_val("e_mdval_o", e_mdval_o, val);
		val = rand16();
		loc_write(1'b1, ETH_GPR, val, 2'b01);
		check_val("dev_ind_o", 16'(dev_ind_o), val & 16'h0007);
		e_mdval_i = rand16();
		loc_expect(1'b1, ETH_MDVAL, e_mdval_i, "lwb_dat_o mdval");
		e_mdstat_i = 8'h80;	// phy idle
		loc_write(1'b1, ETH_MDCTRL, 16'h0020, 2'b01);
		repeat (3) @(negedge lwb_clk_i);
		check_val("e_mdctrl_o", 16'(e_mdctrl_o), 16'h0020);
		@(posedge lwb_clk_i);
		#1;
		e_mdstat_i = '0;	// phy busy, start taken
		n = 0;
		while (e_mdctrl_o[MD_START] && n < 10) begin
			@(negedge lwb_clk_i);
			n++;
		end
		check_val("e_mdctrl_o", 16'(e_mdctrl_o), 16'h0000);
		finish_test("ethernet bank");

		// 6: both buses on the same edge, external first
		fork
			ext_expect(OFS_CSR, 16'h0000, "ewb_dat_o csr");
			loc_expect(1'b0, {1'b0, OFS_CSR}, 16'h0000, "lwb_dat_o csr");
		join
		if (loc_ack_t <= ext_end_t)
			count_failure("local ack came before the external cycle ended");
		e_rxcntb_i = CNT_W'(rand16());	// nonzero count tells the windows apart
		loc_expect(1'b1, ETH_CNT, 16'(e_rxcntb_i), "lwb_dat_o rx count");
		finish_test("arbitration and ack timing");

		$display("tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/delqa_bus_pkg.sv
hdl/delqa_eth_pkg.sv
hdl/qbus_arbiter.sv
hdl/host_regs.sv
hdl/eth_regs.sv
hdl/int_ctrl.sv
hdl/delqa_regs.sv
testbench/tb_delqa_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the delqa register testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_delqa_regs \
	-f sim.f -o sim_delqa || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/sim_delqa)
echo "$out"
grep -qx "Everything OK" <<< "$out" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
